// File: src/cpu_pkg.sv
////////////////////
// CPU shared definitions
// Widths, opcode and funct encodings, and the records passed between stages
////////////////////
package cpu_pkg;

    // Datapath and memory geometry
    localparam int WORD_W         = 32;
    localparam int MEM_ADDR_W     = 8;
    localparam int REG_ADDR_W     = 5;
    localparam int DATA_LOAD_BASE = 255;

    typedef logic [WORD_W-1:0] word_t;

    // Primary opcodes in bits 31..26
    localparam logic [5:0] OP_RTYPE = 6'd0;
    localparam logic [5:0] OP_ADDI  = 6'd1;
    localparam logic [5:0] OP_AND   = 6'd3;
    localparam logic [5:0] OP_OR    = 6'd4;
    localparam logic [5:0] OP_ANDI  = 6'd5;
    localparam logic [5:0] OP_ORI   = 6'd6;
    localparam logic [5:0] OP_SHIFT = 6'd7;
    localparam logic [5:0] OP_LW    = 6'd8;
    localparam logic [5:0] OP_SW    = 6'd9;
    localparam logic [5:0] OP_BEQ   = 6'd10;
    localparam logic [5:0] OP_BNE   = 6'd11;
    localparam logic [5:0] OP_J     = 6'd16;
    localparam logic [5:0] OP_SLT   = 6'd19;
    localparam logic [5:0] OP_SLTI  = 6'd20;

    // Funct codes, meaning depends on the opcode
    localparam logic [5:0] FN_ADD = 6'd0;
    localparam logic [5:0] FN_SUB = 6'd1;
    localparam logic [5:0] FN_SLL = 6'd0;
    localparam logic [5:0] FN_SRL = 6'd1;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRL, ALU_SLT
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH_EQ, CLS_BRANCH_NE, CLS_JUMP, CLS_ILLEGAL
    } instr_class_e;

    // Fetch to decode
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] pc;
        word_t                 instr;
    } fetch_out_t;

    // Decode to execute, target is the taken branch or jump address
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] pc;
        instr_class_e          cls;
        alu_op_e               alu_op;
        word_t                 operand_a;
        word_t                 operand_b;
        word_t                 store_data;
        logic [REG_ADDR_W-1:0] dest;
        logic                  writes_reg;
        logic [MEM_ADDR_W-1:0] target;
    } decoded_t;

    // One record per completed instruction
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] pc;
        logic                  writes_reg;
        logic [REG_ADDR_W-1:0] dest;
        word_t                 value;
        logic                  is_store;
        logic [MEM_ADDR_W-1:0] store_addr;
    } retire_t;

endpackage

// File: src/word_mem.sv
////////////////////
// Word memory
// 256 words, one write port and a registered read port
////////////////////
`timescale 1ns/1ps

module word_mem
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  we,
    input  logic [MEM_ADDR_W-1:0] waddr,
    input  word_t                 wdata,
    input  logic [MEM_ADDR_W-1:0] raddr,
    output word_t                 rdata
);

    // Storage array, contents are undefined until loaded
    word_t mem [2**MEM_ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data appears one cycle after the address
    // A read of the address being written returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: src/reg_file.sv
////////////////////
// Register file
// 32 registers, two combinational reads, one write, r0 reads zero
////////////////////
`timescale 1ns/1ps

module reg_file
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [REG_ADDR_W-1:0] ra_addr,
    input  logic [REG_ADDR_W-1:0] rb_addr,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  word_t                 wdata,
    output word_t                 ra_data,
    output word_t                 rb_data
);

    word_t regs [2**REG_ADDR_W];

    // Writes to r0 are dropped so it never holds a value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Reads are plain lookups because r0 holds zero from reset onward
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];

endmodule

// File: src/program_loader.sv
////////////////////
// Program loader
// Turns load strobes into memory writes and starts the core
////////////////////
`timescale 1ns/1ps

module program_loader
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load_valid,
    input  logic                  load_to_data,
    input  word_t                 load_word,
    input  logic                  start,
    output logic                  imem_we,
    output logic [MEM_ADDR_W-1:0] imem_waddr,
    output word_t                 imem_wdata,
    output logic                  dmem_load_we,
    output logic [MEM_ADDR_W-1:0] dmem_load_addr,
    output word_t                 dmem_load_data,
    output logic [MEM_ADDR_W-1:0] final_addr,
    output logic                  run_enable
);

    logic [MEM_ADDR_W-1:0] instr_addr;
    logic [MEM_ADDR_W-1:0] data_addr;

    // Loads are honoured only while the core is not yet running
    assign imem_we        = load_valid && !load_to_data && !run_enable;
    assign dmem_load_we   = load_valid && load_to_data && !run_enable;
    assign imem_waddr     = instr_addr;
    assign dmem_load_addr = data_addr;
    assign imem_wdata     = load_word;
    assign dmem_load_data = load_word;

    // Instructions fill upward from 0, data fills downward from the top
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_addr <= '0;
            data_addr  <= MEM_ADDR_W'(DATA_LOAD_BASE);
            final_addr <= '0;
            run_enable <= 1'b0;
        end else if (!run_enable) begin
            if (imem_we) instr_addr <= instr_addr + 1'b1;
            if (dmem_load_we) data_addr <= data_addr - 1'b1;
            // The instruction count becomes the end address
            if (start) begin
                final_addr <= instr_addr;
                run_enable <= 1'b1;
            end
        end
    end

endmodule

// File: src/fetch_stage.sv
////////////////////
// Fetch stage
// Holds the PC, reads instruction memory and detects program end
////////////////////
`timescale 1ns/1ps

module fetch_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run_enable,
    input  logic [MEM_ADDR_W-1:0] final_addr,
    input  logic                  pc_valid,
    input  logic [MEM_ADDR_W-1:0] next_pc,
    input  word_t                 imem_rdata,
    output logic [MEM_ADDR_W-1:0] imem_raddr,
    output logic                  fetch_valid,
    output fetch_out_t            fetch_out,
    output logic                  end_signal
);

    logic [MEM_ADDR_W-1:0] pc;
    logic                  run_q;
    logic                  redirect_q;
    logic                  fetch_req;

    // A fetch is requested on the first running cycle and one cycle after each retire
    assign fetch_req = (run_enable && !run_q) || redirect_q;

    // The memory address always follows the PC
    assign imem_raddr = pc;

    // The PC stays put while the word is in flight so it pairs with the read data
    assign fetch_out.pc    = pc;
    assign fetch_out.instr = imem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= '0;
            run_q       <= 1'b0;
            redirect_q  <= 1'b0;
            fetch_valid <= 1'b0;
            end_signal  <= 1'b0;
        end else begin
            run_q      <= run_enable;
            redirect_q <= pc_valid;
            if (pc_valid) pc <= next_pc;
            // Reaching the end address raises end instead of fetching
            fetch_valid <= fetch_req && (pc != final_addr);
            if (fetch_req && pc == final_addr) end_signal <= 1'b1;
        end
    end

endmodule

// File: src/decode_stage.sv
////////////////////
// Decode stage
// Classifies the instruction, reads operands and registers the record
////////////////////
`timescale 1ns/1ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  fetch_valid,
    input  fetch_out_t            fetch_out,
    input  word_t                 ra_data,
    input  word_t                 rb_data,
    output logic [REG_ADDR_W-1:0] ra_addr,
    output logic [REG_ADDR_W-1:0] rb_addr,
    output logic                  dec_valid,
    output decoded_t              dec
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rd;
    logic [15:0]           imm16;
    word_t                 imm_s;
    word_t                 imm_z;
    decoded_t              nxt;

    assign opcode  = fetch_out.instr[31:26];
    assign ra_addr = fetch_out.instr[25:21];
    assign rb_addr = fetch_out.instr[20:16];
    assign rd      = fetch_out.instr[15:11];
    assign funct   = fetch_out.instr[5:0];
    assign imm16   = fetch_out.instr[15:0];
    assign imm_s   = {{(WORD_W-16){imm16[15]}}, imm16};
    assign imm_z   = {{(WORD_W-16){1'b0}}, imm16};

    always_comb begin
        logic [REG_ADDR_W-1:0] dest_sel;
        // Default is an R-type shape that writes nothing
        nxt            = '0;
        nxt.pc         = fetch_out.pc;
        nxt.cls        = CLS_ILLEGAL;
        nxt.alu_op     = ALU_ADD;
        nxt.operand_a  = ra_data;
        nxt.operand_b  = rb_data;
        nxt.store_data = rb_data;
        dest_sel       = rd;
        case (opcode)
            OP_RTYPE: begin
                nxt.cls    = (funct == FN_ADD || funct == FN_SUB) ? CLS_ALU : CLS_ILLEGAL;
                nxt.alu_op = (funct == FN_SUB) ? ALU_SUB : ALU_ADD;
            end
            OP_AND:  {nxt.cls, nxt.alu_op} = {CLS_ALU, ALU_AND};
            OP_OR:   {nxt.cls, nxt.alu_op} = {CLS_ALU, ALU_OR};
            OP_SLT:  {nxt.cls, nxt.alu_op} = {CLS_ALU, ALU_SLT};
            // I-type arithmetic writes rt
            OP_ADDI: {nxt.cls, nxt.alu_op, nxt.operand_b, dest_sel} =
                {CLS_ALU, ALU_ADD, imm_s, rb_addr};
            OP_SLTI: {nxt.cls, nxt.alu_op, nxt.operand_b, dest_sel} =
                {CLS_ALU, ALU_SLT, imm_s, rb_addr};
            // Logical immediates are zero-extended
            OP_ANDI: {nxt.cls, nxt.alu_op, nxt.operand_b, dest_sel} =
                {CLS_ALU, ALU_AND, imm_z, rb_addr};
            OP_ORI:  {nxt.cls, nxt.alu_op, nxt.operand_b, dest_sel} =
                {CLS_ALU, ALU_OR, imm_z, rb_addr};
            OP_SHIFT: begin
                nxt.cls       = (funct == FN_SLL || funct == FN_SRL) ? CLS_ALU : CLS_ILLEGAL;
                nxt.alu_op    = (funct == FN_SRL) ? ALU_SRL : ALU_SLL;
                nxt.operand_b = {{(WORD_W-5){1'b0}}, imm16[4:0]};
                dest_sel      = rb_addr;
            end
            // Memory ops form the address as rs plus the signed offset
            OP_LW:   {nxt.cls, nxt.operand_b, dest_sel} = {CLS_LOAD, imm_s, rb_addr};
            OP_SW:   {nxt.cls, nxt.operand_b} = {CLS_STORE, imm_s};
            // Branches compare rs and rt through a subtract
            OP_BEQ:  {nxt.cls, nxt.alu_op} = {CLS_BRANCH_EQ, ALU_SUB};
            OP_BNE:  {nxt.cls, nxt.alu_op} = {CLS_BRANCH_NE, ALU_SUB};
            OP_J:    nxt.cls = CLS_JUMP;
            default: nxt.cls = CLS_ILLEGAL;
        endcase
        nxt.writes_reg = (nxt.cls == CLS_ALU || nxt.cls == CLS_LOAD) && dest_sel != '0;
        nxt.dest       = nxt.writes_reg ? dest_sel : '0;
        nxt.target     = (opcode == OP_J) ? fetch_out.instr[MEM_ADDR_W-1:0]
                                          : fetch_out.pc + 1'b1 + imm16[MEM_ADDR_W-1:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) dec_valid <= 1'b0;
        else         dec_valid <= fetch_valid;
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) dec <= nxt;
    end

endmodule

// File: src/execute_stage.sv
////////////////////
// Execute stage
// ALU, data memory access, write-back, next PC and retire record
////////////////////
`timescale 1ns/1ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  dec_valid,
    input  decoded_t              dec,
    input  word_t                 dmem_rdata,
    output logic                  dmem_we,
    output logic [MEM_ADDR_W-1:0] dmem_addr,
    output word_t                 dmem_wdata,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output word_t                 rf_wdata,
    output logic                  pc_valid,
    output logic [MEM_ADDR_W-1:0] next_pc,
    output logic                  retire_valid,
    output retire_t               retire
);

    word_t alu_res;
    logic  is_load;
    logic  load_wait;
    logic  done;
    logic  taken;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB: alu_res = dec.operand_a - dec.operand_b;
            ALU_AND: alu_res = dec.operand_a & dec.operand_b;
            ALU_OR:  alu_res = dec.operand_a | dec.operand_b;
            ALU_SLL: alu_res = dec.operand_a << dec.operand_b[4:0];
            ALU_SRL: alu_res = dec.operand_a >> dec.operand_b[4:0];
            ALU_SLT: alu_res = ($signed(dec.operand_a) < $signed(dec.operand_b)) ? 1 : 0;
            default: alu_res = dec.operand_a + dec.operand_b;
        endcase
    end

    // The decoded record holds still until this instruction retires
    assign is_load = dec.cls == CLS_LOAD;
    assign done    = (dec_valid && !is_load) || load_wait;

    // Branch compare uses the subtract result
    assign taken = (dec.cls == CLS_JUMP)
                || (dec.cls == CLS_BRANCH_EQ && alu_res == '0)
                || (dec.cls == CLS_BRANCH_NE && alu_res != '0);

    assign dmem_we    = dec_valid && dec.cls == CLS_STORE;
    assign dmem_addr  = alu_res[MEM_ADDR_W-1:0];
    assign dmem_wdata = dec.store_data;

    // Loads write back in the wait cycle, everything else in the issue cycle
    assign rf_we    = done && dec.writes_reg;
    assign rf_waddr = dec.dest;
    assign rf_wdata = load_wait ? dmem_rdata : alu_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_wait    <= 1'b0;
            pc_valid     <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            load_wait    <= dec_valid && is_load;
            pc_valid     <= done;
            retire_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            next_pc           <= taken ? dec.target : dec.pc + 1'b1;
            retire.pc         <= dec.pc;
            retire.writes_reg <= dec.writes_reg;
            retire.dest       <= dec.dest;
            retire.is_store   <= dec.cls == CLS_STORE;
            retire.store_addr <= (dec.cls == CLS_STORE) ? dmem_addr : '0;
            // Stores report the stored word, writers the written one
            if (dec.cls == CLS_STORE) retire.value <= dec.store_data;
            else if (dec.writes_reg)  retire.value <= rf_wdata;
            else                      retire.value <= '0;
        end
    end

endmodule

// File: src/cpu_top.sv
////////////////////
// CPU top level
// Loader, memories, register file and the three stages
////////////////////
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    load_valid,
    input  logic    load_to_data,
    input  word_t   load_word,
    input  logic    start,
    output logic    retire_valid,
    output retire_t retire,
    output logic    end_signal
);

    logic                  imem_we, dmem_load_we, run_enable;
    logic [MEM_ADDR_W-1:0] imem_waddr, imem_raddr, dmem_load_addr, final_addr;
    word_t                 imem_wdata, imem_rdata, dmem_load_data;
    logic                  fetch_valid, dec_valid, pc_valid;
    fetch_out_t            fetch_out;
    decoded_t              dec;
    logic [MEM_ADDR_W-1:0] next_pc;
    logic [REG_ADDR_W-1:0] ra_addr, rb_addr, rf_waddr;
    word_t                 ra_data, rb_data, rf_wdata;
    logic                  rf_we;
    logic                  ex_dmem_we, dmem_we;
    logic [MEM_ADDR_W-1:0] ex_dmem_addr, dmem_waddr;
    word_t                 ex_dmem_wdata, dmem_wdata, dmem_rdata;

    // Data memory write port belongs to the loader until the core runs
    assign dmem_we    = run_enable ? ex_dmem_we    : dmem_load_we;
    assign dmem_waddr = run_enable ? ex_dmem_addr  : dmem_load_addr;
    assign dmem_wdata = run_enable ? ex_dmem_wdata : dmem_load_data;

    program_loader u_loader (.*);

    word_mem u_imem (
        .clk, .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
        .raddr(imem_raddr), .rdata(imem_rdata)
    );

    word_mem u_dmem (
        .clk, .we(dmem_we), .waddr(dmem_waddr), .wdata(dmem_wdata),
        .raddr(ex_dmem_addr), .rdata(dmem_rdata)
    );

    reg_file u_rf (
        .clk, .arst_n, .ra_addr, .rb_addr, .we(rf_we), .waddr(rf_waddr),
        .wdata(rf_wdata), .ra_data, .rb_data
    );

    fetch_stage u_fetch (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (
        .clk, .arst_n, .dec_valid, .dec, .dmem_rdata,
        .dmem_we(ex_dmem_we), .dmem_addr(ex_dmem_addr), .dmem_wdata(ex_dmem_wdata),
        .rf_we, .rf_waddr, .rf_wdata, .pc_valid, .next_pc, .retire_valid, .retire
    );

endmodule

// File: tests/cpu_checker.sv
////////////////////
// CPU protocol checker
// Assertions on the retire trace and end_signal of the core
////////////////////
`timescale 1ns/1ps

module cpu_checker
    import cpu_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    run_enable,
    input logic    retire_valid,
    input retire_t retire,
    input logic    end_signal
);

    // Nothing retires until the start strobe has set run_enable
    assert property (@(posedge clk) disable iff (!arst_n) retire_valid |-> run_enable)
        else $error("retire_valid seen before start");

    // end_signal is sticky until reset
    assert property (@(posedge clk) disable iff (!arst_n) end_signal |=> end_signal)
        else $error("end_signal dropped after rising");

    // A register write to r0 must never be reported
    assert property (@(posedge clk) disable iff (!arst_n)
        (retire_valid && retire.writes_reg) |-> (retire.dest != '0))
        else $error("retire record writes register 0");

    // The core is idle once it has ended
    assert property (@(posedge clk) disable iff (!arst_n) retire_valid |-> !end_signal)
        else $error("retire_valid seen while end_signal is high");

endmodule

bind cpu_top cpu_checker u_checker (
    .clk(clk),
    .arst_n(arst_n),
    .run_enable(run_enable),
    .retire_valid(retire_valid),
    .retire(retire),
    .end_signal(end_signal)
);

// File: tests/tb_cpu.sv
////////////////////
// CPU testbench
// Loads a program from the stim file and checks the retire trace
////////////////////
`timescale 1ns/1ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam int RETIRE_TIMEOUT = 50;
    localparam int END_TIMEOUT    = 50;

    logic    clk = 1'b0;
    logic    arst_n;
    logic    load_valid;
    logic    load_to_data;
    word_t   load_word;
    logic    start;
    logic    retire_valid;
    retire_t retire;
    logic    end_signal;

    // Load sequence and expected trace, filled from the stim file
    logic [7:0]        load_kind_q [$];
    word_t             load_data_q [$];
    retire_t           exp_q [$];
    int                exp_group_q [$];
    logic [8*16-1:0]   group_name [8];
    int                n_groups = 0;
    int                exp_count = 0;
    int                errors = 0;
    int                checks = 0;
    int                retire_count = 0;
    logic [31:0]       rng = 32'h7009;

    cpu_top u_dut (
        .clk, .arst_n, .load_valid, .load_to_data, .load_word, .start,
        .retire_valid, .retire, .end_signal
    );

    always #5 clk = ~clk;

    // Every retire strobe is counted so that late extra retires show up
    always @(negedge clk) begin
        if (arst_n && retire_valid) retire_count++;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic read_stim();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [31:0]      f [6];
        logic [8*200-1:0] line;
        retire_t          rec;
        fd = $fopen("tests/cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/cpu_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) break;
            case (tag)
                "#": code = $fgets(line, fd);
                "I", "D": begin
                    code = $fscanf(fd, " %h", f[0]);
                    load_kind_q.push_back(tag);
                    load_data_q.push_back(f[0]);
                end
                "S": begin
                    load_kind_q.push_back(tag);
                    load_data_q.push_back('0);
                end
                "T": begin
                    code = $fscanf(fd, " %s", group_name[n_groups]);
                    n_groups++;
                end
                "R": begin
                    code = $fscanf(fd, " %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    rec.pc         = f[0][MEM_ADDR_W-1:0];
                    rec.writes_reg = f[1][0];
                    rec.dest       = f[2][REG_ADDR_W-1:0];
                    rec.value      = f[3];
                    rec.is_store   = f[4][0];
                    rec.store_addr = f[5][MEM_ADDR_W-1:0];
                    exp_q.push_back(rec);
                    exp_group_q.push_back(n_groups - 1);
                end
                "E": code = $fscanf(fd, " %d", exp_count);
                default: begin
                    $display("Unknown record tag %c in the stimulus file", tag);
                    errors++;
                end
            endcase
        end
        $fclose(fd);
    endtask

    // Plays the load sequence with 0 to 3 idle cycles before each strobe
    task automatic drive_loads();
        int idle;
        for (int i = 0; i < load_kind_q.size(); i++) begin
            rng  = xorshift32(rng);
            idle = int'(rng[1:0]);
            repeat (idle) @(negedge clk);
            load_valid   = (load_kind_q[i] != "S");
            load_to_data = (load_kind_q[i] == "D");
            load_word    = load_data_q[i];
            start        = (load_kind_q[i] == "S");
            @(negedge clk);
            load_valid = 1'b0;
            start      = 1'b0;
        end
    endtask

    // Always steps past the current cycle so one strobe is never taken twice
    task automatic wait_retire(output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!retire_valid && n < RETIRE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = retire_valid;
    endtask

    task automatic compare_retire(input retire_t exp);
        check_field("retire.pc", 32'(retire.pc), 32'(exp.pc));
        check_field("retire.writes_reg", 32'(retire.writes_reg), 32'(exp.writes_reg));
        check_field("retire.dest", 32'(retire.dest), 32'(exp.dest));
        check_field("retire.value", retire.value, exp.value);
        check_field("retire.is_store", 32'(retire.is_store), 32'(exp.is_store));
        check_field("retire.store_addr", 32'(retire.store_addr), 32'(exp.store_addr));
    endtask

    initial begin
        int   idx;
        int   n;
        int   grp_err;
        int   grp_n;
        logic ok;
        logic stopped;
        arst_n       = 1'b0;
        load_valid   = 1'b0;
        load_to_data = 1'b0;
        load_word    = '0;
        start        = 1'b0;
        idx          = 0;
        stopped      = 1'b0;
        read_stim();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        drive_loads();
        $display("load: %0d records driven", load_kind_q.size());

        // Expected records are consumed in order, one group at a time
        for (int g = 0; g < n_groups && !stopped; g++) begin
            grp_err = errors;
            grp_n   = 0;
            while (idx < exp_q.size() && exp_group_q[idx] == g && !stopped) begin
                wait_retire(ok);
                if (!ok) begin
                    $display("Timeout: no retire arrived for expected pc %0d", exp_q[idx].pc);
                    errors++;
                    stopped = 1'b1;
                end else begin
                    compare_retire(exp_q[idx]);
                    grp_n++;
                end
                idx++;
            end
            $display("test %0s: %0d retires, %0d errors", group_name[g], grp_n,
                     errors - grp_err);
        end

        // The core must end on its own and stay quiet afterwards
        grp_err = errors;
        n       = 0;
        while (!end_signal && n < END_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!end_signal) begin
            $display("Timeout: end_signal did not rise after the last retire");
            errors++;
        end
        repeat (20) @(negedge clk);
        check_field("end_signal", 32'(end_signal), 32'd1);
        check_field("retire_count", 32'(retire_count), 32'(exp_count));
        $display("test termination: %0d retires seen, %0d errors", retire_count,
                 errors - grp_err);

        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
src/cpu_pkg.sv
src/word_mem.sv
src/reg_file.sv
src/program_loader.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/cpu_top.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

// File: run.sh
#!/bin/sh
# Builds the CPU testbench with Verilator, runs it and scans the log for the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cpu -f all.f -o sim_cpu

# The log decides the result, so the simulator's own status is not used here
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q '>>> FAIL' sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q '>>> PASS' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation finished without errors"

// File: tests/cpu_stim.txt
# Load records are I for an instruction word, D for a data word and S for the start strobe
# R pc writes_reg dest value is_store store_addr gives the expected retire of that instruction in hex
# T names a test group and E gives the decimal retire count before end
D 00000007
D FFFFFFFD
D 123400F0
T arith_logic
I 2001FFFF R 00 1 01 00000007 0 00
I 2002FFFE R 01 1 02 FFFFFFFD 0 00
I 2003FFFD R 02 1 03 123400F0 0 00
I 00222000 R 03 1 04 00000004 0 00
I 00222801 R 04 1 05 0000000A 0 00
I 0426FFF6 R 05 1 06 FFFFFFFD 0 00
I 0C453800 R 06 1 07 00000008 0 00
I 10614000 R 07 1 08 123400F7 0 00
I 1449F0F0 R 08 1 09 0000F0F0 0 00
I 180A8001 R 09 1 0A 00008001 0 00
T shift_compare
I 1C6B0000 R 0A 1 0B 123400F0 0 00
I 1C4C0001 R 0B 1 0C 7FFFFFFE 0 00
I 4C416800 R 0C 1 0D 00000001 0 00
I 4C227000 R 0D 1 0E 00000000 0 00
I 504FFFFE R 0E 1 0F 00000001 0 00
T memory
I 2408FFFB R 0F 0 00 123400F7 1 FB
I 2010FFFB R 10 1 10 123400F7 0 00
I 24850002 R 11 0 00 0000000A 1 06
I 20110006 R 12 1 11 0000000A 0 00
T control_flow
I 28240005 R 13 0 00 00000000 0 00
I 29630002 R 14 0 00 00000000 0 00
I 04120111
I 04120222
I 2C210003 R 17 0 00 00000000 0 00
I 2C220001 R 18 0 00 00000000 0 00
I 04120333
I 4000001C R 1A 0 00 00000000 0 00
I 04120444
T register_zero
I 04200005 R 1C 0 00 00000000 0 00
I 00019800 R 1D 1 13 00000007 0 00
S
E 26
